// File: bench/lsu_golden.txt
# op amo addr rs2 expected, all hex; expected is data_o (addr for stores)
# a misaligned atomic line checks amo_misalign_o, its expected column is unused
8 0 00000010 80f17f82 00000010
1 0 00000010 00000000 ffffff82
2 0 00000011 00000000 0000007f
1 0 00000012 00000000 fffffff1
2 0 00000013 00000000 00000080
3 0 00000012 00000000 ffff80f1
4 0 00000010 00000000 00007f82
6 0 00000011 000000aa 00000011
7 0 00000012 00005566 00000012
5 0 00000010 00000000 5566aa82
5 0 0200bff8 00000000 12345678
8 0 02004000 0000beef 02004000
8 0 00000020 00000010 00000020
b 0 00000020 fffffff0 00000010
b 1 00000020 00000020 fffffff0
b 2 00000020 000000ff 00000010
b 3 00000020 0000000f 000000ef
b 4 00000020 80000000 0000000f
b 6 00000020 00000100 8000000f
b 5 00000020 fffffffe 00000100
b 7 00000020 00000300 fffffffe
b 8 00000020 80000000 00000300
5 0 00000020 00000000 80000000
9 0 00000020 00000000 80000000
a 0 00000020 00001234 00000000
9 0 00000020 00000000 00001234
8 0 00000030 00000000 00000030
a 0 00000020 00009999 00000001
9 0 00000020 00000000 00001234
a 0 00000024 00007777 00000001
5 0 00000020 00000000 00001234
5 0 00000024 00000000 c0de0009
b 1 00000022 00000001 00000000
5 0 00000020 00000000 00001234

// File: lsu.f
+incdir+common
common/lsu_pkg.sv
hdl/access_ctrl.sv
hdl/load_align.sv
amo/amo_unit.sv
hdl/lsu_top.sv
bench/lsu_checker.sv
bench/lsu_monitor.sv
bench/lsu_tb.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vlsu_tb: lsu.f common/lsu_defs.svh common/lsu_pkg.sv hdl/*.sv amo/*.sv bench/*.sv
	verilator --binary --timing --assert --top-module lsu_tb -f lsu.f

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module lsu_tb -f lsu.f

clean:
	rm -rf obj_dir sim.log

// File: bench/lsu_tb.sv
`include "lsu_defs.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    logic        clk;
    logic        rst;
    mem_op_e     mem_op_i;
    amo_op_e     amo_op_i;
    logic [31:0] addr_i;
    logic [31:0] rs2_i;
    logic        amo_start_i;
    logic        mem_ready_i;
    logic [31:0] mem_rdata_i;
    logic [31:0] clint_rdata_i;
    logic        mem_req_o;
    logic        mem_we_o;
    logic [31:0] mem_addr_o;
    logic [3:0]  mem_mask_o;
    logic [31:0] mem_wdata_o;
    logic        clint_sel_o;
    logic        clint_we_o;
    logic [31:0] clint_wdata_o;
    logic [31:0] data_o;
    logic        amo_done_o;
    logic        amo_misalign_o;
    logic        stall_o;

    // golden lines and driver state
    logic [31:0] g_op   [0:63];
    logic [31:0] g_amo  [0:63];
    logic [31:0] g_addr [0:63];
    logic [31:0] g_rs2  [0:63];
    logic [31:0] g_exp  [0:63];
    int          n_lines;
    int          line_no;
    logic        active;
    logic [31:0] exp_data;
    logic        retire;
    logic        timeout;
    int          test_cnt;
    int          err_cnt;

    // cache model
    logic [31:0] mem [0:63];
    int          busy_cnt;
    int          lat;
    integer      i;
    integer      b;

    lsu_top uut (
        .clk(clk), .rst(rst), .mem_op_i(mem_op_i), .amo_op_i(amo_op_i),
        .addr_i(addr_i), .rs2_i(rs2_i), .amo_start_i(amo_start_i),
        .mem_ready_i(mem_ready_i), .mem_rdata_i(mem_rdata_i),
        .clint_rdata_i(clint_rdata_i), .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_mask_o(mem_mask_o), .mem_wdata_o(mem_wdata_o),
        .clint_sel_o(clint_sel_o), .clint_we_o(clint_we_o),
        .clint_wdata_o(clint_wdata_o), .data_o(data_o), .amo_done_o(amo_done_o),
        .amo_misalign_o(amo_misalign_o), .stall_o(stall_o)
    );

    lsu_monitor u_monitor (
        .clk(clk), .rst(rst), .active_i(active), .line_no_i(line_no),
        .n_lines_i(n_lines), .exp_data_i(exp_data), .mem_op_i(mem_op_i),
        .addr_i(addr_i), .rs2_i(rs2_i), .mem_req_i(mem_req_o),
        .mem_ready_i(mem_ready_i), .clint_sel_i(clint_sel_o),
        .clint_we_i(clint_we_o), .clint_wdata_i(clint_wdata_o), .data_i(data_o),
        .amo_done_i(amo_done_o), .amo_misalign_i(amo_misalign_o), .stall_i(stall_o),
        .retire_o(retire), .timeout_o(timeout),
        .test_cnt_o(test_cnt), .err_cnt_o(err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // count request cycles and pick a fresh latency per access
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_cnt <= 0;
            lat      <= 1;
            for (i = 0; i < 64; i = i + 1) begin
                mem[i] <= 32'hc0de_0000 + i;
            end
        end else if (mem_ready_i) begin
            busy_cnt <= 0;
            if (mem_req_o && mem_we_o) begin
                for (b = 0; b < 4; b = b + 1) begin
                    if (mem_mask_o[b]) begin
                        mem[mem_addr_o[7:2]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
                    end
                end
            end
        end else if (mem_req_o) begin
            if (busy_cnt == 0) begin
                lat <= 1 + int'($urandom % 3);
            end
            busy_cnt <= busy_cnt + 1;
        end
    end

    // ready strobe and read data on the falling edge
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            mem_ready_i <= 1'b0;
            mem_rdata_i <= 32'd0;
        end else if (!mem_ready_i && busy_cnt != 0 && busy_cnt >= lat) begin
            mem_ready_i <= 1'b1;
            mem_rdata_i <= mem[mem_addr_o[7:2]];
        end else begin
            mem_ready_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (timeout) begin
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int    fd;
        int    cnt;
        int    k;
        string text;

        void'($urandom(15));
        rst           = 1'b1;
        mem_op_i      = NONE;
        amo_op_i      = SWAP;
        addr_i        = 32'd0;
        rs2_i         = 32'd0;
        amo_start_i   = 1'b0;
        clint_rdata_i = 32'h1234_5678;
        active        = 1'b0;
        exp_data      = 32'd0;
        line_no       = 0;
        n_lines       = 0;

        // load golden lines and skip comment lines
        fd = $fopen("bench/lsu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/lsu_golden.txt");
            $display("sim failed");
            $finish;
        end else begin
            while (!$feof(fd) && n_lines < 64) begin
                cnt = $fgets(text, fd);
                if (cnt > 0 && text.getc(0) != 8'h23) begin
                    cnt = $sscanf(text, "%h %h %h %h %h", g_op[n_lines], g_amo[n_lines],
                                  g_addr[n_lines], g_rs2[n_lines], g_exp[n_lines]);
                    if (cnt == 5) begin
                        n_lines = n_lines + 1;
                    end
                end
            end
            $fclose(fd);

            repeat (5) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            @(negedge clk);

            // each line goes out on the falling edge that saw the previous one retire
            for (k = 0; k < n_lines; k = k + 1) begin
                mem_op_i    = mem_op_e'(g_op[k][3:0]);
                amo_op_i    = amo_op_e'(g_amo[k][3:0]);
                addr_i      = g_addr[k];
                rs2_i       = g_rs2[k];
                exp_data    = g_exp[k];
                line_no     = k + 1;
                active      = 1'b1;
                // start strobe only in the first cycle of an atomic
                amo_start_i = (mem_op_i == LR_W) || (mem_op_i == SC_W) || (mem_op_i == AMO);
                @(negedge clk);
                amo_start_i = 1'b0;
                while (!retire) begin
                    @(negedge clk);
                end
            end

            active   = 1'b0;
            mem_op_i = NONE;
            repeat (3) @(negedge clk);
            $display("tests run %0d, tests failed %0d", test_cnt, err_cnt);
            if (err_cnt == 0 && test_cnt == n_lines) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

// File: bench/lsu_monitor.sv
`include "lsu_defs.svh"

module lsu_monitor (
    input  logic             clk,
    input  logic             rst,
    input  logic             active_i,
    input  int               line_no_i,
    input  int               n_lines_i,
    input  logic [31:0]      exp_data_i,
    input  lsu_pkg::mem_op_e mem_op_i,
    input  logic [31:0]      addr_i,
    input  logic [31:0]      rs2_i,
    input  logic             mem_req_i,
    input  logic             mem_ready_i,
    input  logic             clint_sel_i,
    input  logic             clint_we_i,
    input  logic [31:0]      clint_wdata_i,
    input  logic [31:0]      data_i,
    input  logic             amo_done_i,
    input  logic             amo_misalign_i,
    input  logic             stall_i,
    output logic             retire_o,
    output logic             timeout_o,
    output int               test_cnt_o,
    output int               err_cnt_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    logic is_amo;
    logic is_store;
    logic is_timer;
    logic misaligned;
    logic line_bad;
    int   wait_cnt;
    int   cyc;

    // expected routing from the op and the address
    assign is_amo     = (mem_op_i == LR_W) || (mem_op_i == SC_W) || (mem_op_i == AMO);
    assign is_store   = (mem_op_i == SB) || (mem_op_i == SH) || (mem_op_i == SW);
    assign is_timer   = (addr_i == `MTIME_LO) || (addr_i == `MTIME_HI) ||
                        (addr_i == `MTIMECMP_LO) || (addr_i == `MTIMECMP_HI);
    assign misaligned = is_amo && (addr_i[1:0] != 2'b00);

    task automatic compare_word(input string name, input logic [31:0] expv,
                                input logic [31:0] actv);
        if (actv !== expv) begin
            $display("error at %0t ns: %s expected %h got %h", $time, name, expv, actv);
            line_bad = 1'b1;
        end
    endtask

    task automatic close_test();
        test_cnt_o = test_cnt_o + 1;
        if (line_bad) begin
            err_cnt_o = err_cnt_o + 1;
            $display("line %0d failed", line_no_i);
        end else begin
            $display("line %0d ok", line_no_i);
        end
        line_bad = 1'b0;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_o   <= 1'b0;
            timeout_o  <= 1'b0;
            wait_cnt   <= 0;
            cyc        <= 0;
            test_cnt_o = 0;
            err_cnt_o  = 0;
            line_bad   = 1'b0;
        end else begin
            retire_o <= 1'b0;
            cyc      <= cyc + 1;
            // run budget of the worst atomic per line plus slack
            if (cyc >= n_lines_i * 16 + 40 && !timeout_o) begin
                $display("timeout: run did not finish within %0d cycles", cyc);
                timeout_o <= 1'b1;
            end
            if (active_i && !retire_o) begin
                wait_cnt <= wait_cnt + 1;
                if (misaligned) begin
                    // trap flag without cache traffic or stall
                    compare_word("amo_misalign_o", 32'd1, {31'd0, amo_misalign_i});
                    compare_word("mem_req_o", 32'd0, {31'd0, mem_req_i});
                    compare_word("stall_o", 32'd0, {31'd0, stall_i});
                    close_test();
                    retire_o <= 1'b1;
                    wait_cnt <= 0;
                end else if (is_amo && amo_done_i) begin
                    compare_word("data_o", exp_data_i, data_i);
                    close_test();
                    retire_o <= 1'b1;
                    wait_cnt <= 0;
                end else if (!is_amo && is_timer) begin
                    compare_word("mem_req_o", 32'd0, {31'd0, mem_req_i});
                    compare_word("clint_sel_o", 32'd1, {31'd0, clint_sel_i});
                    compare_word("clint_we_o", {31'd0, is_store}, {31'd0, clint_we_i});
                    // timer registers are word aligned so the store word is unshifted
                    if (is_store) begin
                        compare_word("clint_wdata_o", rs2_i, clint_wdata_i);
                    end
                    compare_word("stall_o", 32'd0, {31'd0, stall_i});
                    compare_word("data_o", exp_data_i, data_i);
                    close_test();
                    retire_o <= 1'b1;
                    wait_cnt <= 0;
                end else if (!is_amo && mem_req_i && mem_ready_i) begin
                    compare_word("data_o", exp_data_i, data_i);
                    close_test();
                    retire_o <= 1'b1;
                    wait_cnt <= 0;
                end else if (wait_cnt > 20) begin
                    $display("line %0d: access never completed, no ready or done seen",
                             line_no_i);
                    line_bad = 1'b1;
                    close_test();
                    retire_o <= 1'b1;
                    wait_cnt <= 0;
                end else begin
                    // access still open so the pipe must be held
                    compare_word("stall_o", 32'd1, {31'd0, stall_i});
                end
            end
        end
    end

endmodule

// File: bench/lsu_checker.sv
`include "lsu_defs.svh"

module lsu_checker (
    input logic             clk,
    input logic             rst,
    input logic             mem_req_i,
    input logic             mem_ready_i,
    input logic             amo_done_i,
    input logic             stall_i,
    input lsu_pkg::mem_op_e mem_op_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    // request is a level, held until the ready strobe
    req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req_i && !mem_ready_i) |=> mem_req_i)
        else $error("mem_req_o dropped before mem_ready_i");

    // done is a single cycle strobe
    done_pulse: assert property (@(posedge clk) disable iff (rst)
        amo_done_i |=> !amo_done_i)
        else $error("amo_done_o high for more than one cycle");

    // no stall without an op
    idle_no_stall: assert property (@(posedge clk) disable iff (rst)
        (mem_op_i == NONE) |-> !stall_i)
        else $error("stall_o high with no op presented");

endmodule

bind lsu_top lsu_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .mem_req_i   (mem_req_o),
    .mem_ready_i (mem_ready_i),
    .amo_done_i  (amo_done_o),
    .stall_i     (stall_o),
    .mem_op_i    (mem_op_i)
);

// File: hdl/lsu_top.sv
`include "lsu_defs.svh"

module lsu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::mem_op_e      mem_op_i,
    input  lsu_pkg::amo_op_e      amo_op_i,
    input  logic [`XLEN-1:0]      addr_i,
    input  logic [`XLEN-1:0]      rs2_i,
    input  logic                  amo_start_i,
    input  logic                  mem_ready_i,
    input  logic [`XLEN-1:0]      mem_rdata_i,
    input  logic [`XLEN-1:0]      clint_rdata_i,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [`XLEN-1:0]      mem_addr_o,
    output logic [`XLEN/8-1:0]    mem_mask_o,
    output logic [`XLEN-1:0]      mem_wdata_o,
    output logic                  clint_sel_o,
    output logic                  clint_we_o,
    output logic [`XLEN-1:0]      clint_wdata_o,
    output logic [`XLEN-1:0]      data_o,
    output logic                  amo_done_o,
    output logic                  amo_misalign_o,
    output logic                  stall_o
);
    import lsu_pkg::*;

    // raw word from cache or timer, before lane select
    rd_word_u          raw_word;
    logic [`XLEN-1:0]  load_data;

    // atomic unit towards the cache port
    logic              amo_busy;
    logic              amo_req;
    logic              amo_we;
    logic [`XLEN-1:0]  amo_wdata;
    logic [`XLEN-1:0]  amo_result;
    logic              plain_store;

    access_ctrl u_access_ctrl (
        .mem_op_i      (mem_op_i),
        .addr_i        (addr_i),
        .rs2_i         (rs2_i),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .clint_rdata_i (clint_rdata_i),
        .load_data_i   (load_data),
        .amo_busy_i    (amo_busy),
        .amo_req_i     (amo_req),
        .amo_we_i      (amo_we),
        .amo_wdata_i   (amo_wdata),
        .amo_result_i  (amo_result),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_mask_o    (mem_mask_o),
        .mem_wdata_o   (mem_wdata_o),
        .clint_sel_o   (clint_sel_o),
        .clint_we_o    (clint_we_o),
        .clint_wdata_o (clint_wdata_o),
        .rdata_o       (raw_word),
        .data_o        (data_o),
        .stall_o       (stall_o),
        .plain_store_o (plain_store)
    );

    load_align u_load_align (
        .rdata_i   (raw_word),
        .addr_lo_i (addr_i[1:0]),
        .mem_op_i  (mem_op_i),
        .data_o    (load_data)
    );

    amo_unit u_amo_unit (
        .clk           (clk),
        .rst           (rst),
        .amo_start_i   (amo_start_i),
        .mem_op_i      (mem_op_i),
        .amo_op_i      (amo_op_i),
        .addr_i        (addr_i),
        .rs2_i         (rs2_i),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .plain_store_i (plain_store),
        .busy_o        (amo_busy),
        .req_o         (amo_req),
        .we_o          (amo_we),
        .wdata_o       (amo_wdata),
        .result_o      (amo_result),
        .done_o        (amo_done_o),
        .misalign_o    (amo_misalign_o)
    );

endmodule

// File: amo/amo_unit.sv
`include "lsu_defs.svh"

module amo_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  amo_start_i,
    input  lsu_pkg::mem_op_e      mem_op_i,
    input  lsu_pkg::amo_op_e      amo_op_i,
    input  logic [`XLEN-1:0]      addr_i,
    input  logic [`XLEN-1:0]      rs2_i,
    input  logic                  mem_ready_i,
    input  logic [`XLEN-1:0]      mem_rdata_i,
    input  logic                  plain_store_i,
    output logic                  busy_o,
    output logic                  req_o,
    output logic                  we_o,
    output logic [`XLEN-1:0]      wdata_o,
    output logic [`XLEN-1:0]      result_o,
    output logic                  done_o,
    output logic                  misalign_o
);
    import lsu_pkg::*;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_LOAD  = 2'd1;
    localparam logic [1:0] S_CALC  = 2'd2;
    localparam logic [1:0] S_STORE = 2'd3;

    logic [1:0]        state_q;
    logic              done_q;
    logic              rsv_valid_q;
    logic [`XLEN-1:0]  rsv_addr_q;
    logic [`XLEN-1:0]  loaded_q;
    logic [`XLEN-1:0]  calc_q;
    logic [`XLEN-1:0]  result_q;
    logic [`XLEN-1:0]  calc_val;
    logic              is_lr;
    logic              is_sc;
    logic              is_atomic;
    logic              rsv_hit;
    logic              start_ok;
    logic              sc_fail;
    logic              ld_done;
    logic              st_done;

    assign is_lr     = (mem_op_i == LR_W);
    assign is_sc     = (mem_op_i == SC_W);
    assign is_atomic = is_lr || is_sc || (mem_op_i == AMO);

    // atomics must be word aligned, trap instead of starting
    assign misalign_o = is_atomic && (addr_i[1:0] != 2'b00);

    assign rsv_hit  = rsv_valid_q && (rsv_addr_q == addr_i);
    assign start_ok = (state_q == S_IDLE) && amo_start_i && is_atomic && !misalign_o;
    assign sc_fail  = start_ok && is_sc && !rsv_hit;
    assign ld_done  = (state_q == S_LOAD) && mem_ready_i;
    assign st_done  = (state_q == S_STORE) && mem_ready_i;

    // rmw arithmetic on the loaded word
    always_comb begin
        case (amo_op_i)
            SWAP:    calc_val = rs2_i;
            ADD:     calc_val = loaded_q + rs2_i;
            XOR:     calc_val = loaded_q ^ rs2_i;
            AND:     calc_val = loaded_q & rs2_i;
            OR:      calc_val = loaded_q | rs2_i;
            MIN:     calc_val = ($signed(loaded_q) < $signed(rs2_i)) ? loaded_q : rs2_i;
            MAX:     calc_val = ($signed(loaded_q) > $signed(rs2_i)) ? loaded_q : rs2_i;
            MINU:    calc_val = (loaded_q < rs2_i) ? loaded_q : rs2_i;
            MAXU:    calc_val = (loaded_q > rs2_i) ? loaded_q : rs2_i;
            default: calc_val = rs2_i;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= S_IDLE;
            done_q      <= 1'b0;
            rsv_valid_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_ok) begin
                        if (!is_sc) begin
                            state_q <= S_LOAD;
                        end else if (rsv_hit) begin
                            state_q <= S_STORE;
                        end else begin
                            // failed sc finishes without touching memory
                            done_q      <= 1'b1;
                            rsv_valid_q <= 1'b0;
                        end
                    end
                end
                S_LOAD: begin
                    if (mem_ready_i) begin
                        if (is_lr) begin
                            state_q     <= S_IDLE;
                            done_q      <= 1'b1;
                            rsv_valid_q <= 1'b1;
                        end else begin
                            state_q <= S_CALC;
                        end
                    end
                end
                S_CALC: begin
                    state_q <= S_STORE;
                end
                S_STORE: begin
                    if (mem_ready_i) begin
                        state_q     <= S_IDLE;
                        done_q      <= 1'b1;
                        rsv_valid_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
            // plain store anywhere drops the reservation
            if (plain_store_i) begin
                rsv_valid_q <= 1'b0;
            end
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        if (ld_done) begin
            loaded_q <= mem_rdata_i;
        end
        if (state_q == S_CALC) begin
            calc_q <= calc_val;
        end
        if (ld_done && is_lr) begin
            result_q   <= mem_rdata_i;
            rsv_addr_q <= addr_i;
        end else if (st_done) begin
            // sc reports success, rmw returns the old value
            result_q <= is_sc ? '0 : loaded_q;
        end else if (sc_fail) begin
            result_q <= `XLEN'(`SC_FAIL);
        end
    end

    assign busy_o   = start_ok || (state_q != S_IDLE);
    assign req_o    = (state_q == S_LOAD) || (state_q == S_STORE);
    assign we_o     = (state_q == S_STORE);
    assign wdata_o  = is_sc ? rs2_i : calc_q;
    assign result_o = result_q;
    assign done_o   = done_q;

endmodule

// File: hdl/load_align.sv
`include "lsu_defs.svh"

module load_align (
    input  lsu_pkg::rd_word_u     rdata_i,
    input  logic [1:0]            addr_lo_i,
    input  lsu_pkg::mem_op_e      mem_op_i,
    output logic [`XLEN-1:0]      data_o
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // byte lane by both low bits, half by bit 1
    assign sel_byte = rdata_i.lanes[addr_lo_i];
    assign sel_half = rdata_i.halves[addr_lo_i[1]];

    always_comb begin
        case (mem_op_i)
            LB: begin
                data_o = {{(`XLEN-8){sel_byte[7]}}, sel_byte};
            end
            LBU: begin
                data_o = {{(`XLEN-8){1'b0}}, sel_byte};
            end
            LH: begin
                data_o = {{(`XLEN-16){sel_half[15]}}, sel_half};
            end
            LHU: begin
                data_o = {{(`XLEN-16){1'b0}}, sel_half};
            end
            // full word for lw
            default: begin
                data_o = rdata_i;
            end
        endcase
    end

endmodule

// File: hdl/access_ctrl.sv
`include "lsu_defs.svh"

module access_ctrl (
    input  lsu_pkg::mem_op_e      mem_op_i,
    input  logic [`XLEN-1:0]      addr_i,
    input  logic [`XLEN-1:0]      rs2_i,
    input  logic                  mem_ready_i,
    input  logic [`XLEN-1:0]      mem_rdata_i,
    input  logic [`XLEN-1:0]      clint_rdata_i,
    input  logic [`XLEN-1:0]      load_data_i,
    input  logic                  amo_busy_i,
    input  logic                  amo_req_i,
    input  logic                  amo_we_i,
    input  logic [`XLEN-1:0]      amo_wdata_i,
    input  logic [`XLEN-1:0]      amo_result_i,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [`XLEN-1:0]      mem_addr_o,
    output logic [`XLEN/8-1:0]    mem_mask_o,
    output logic [`XLEN-1:0]      mem_wdata_o,
    output logic                  clint_sel_o,
    output logic                  clint_we_o,
    output logic [`XLEN-1:0]      clint_wdata_o,
    output lsu_pkg::rd_word_u     rdata_o,
    output logic [`XLEN-1:0]      data_o,
    output logic                  stall_o,
    output logic                  plain_store_o
);
    import lsu_pkg::*;

    logic                 is_load;
    logic                 is_store;
    logic                 is_atomic;
    logic                 sz_byte;
    logic                 sz_half;
    logic [`XLEN/8-1:0]   rmask;
    logic [`XLEN/8-1:0]   wmask;
    logic [`XLEN-1:0]     wdata_sh;
    logic                 timer_hit;
    logic                 plain_req;

    // direction and size from the op
    assign is_load   = (mem_op_i == LB) || (mem_op_i == LBU) || (mem_op_i == LH) ||
                       (mem_op_i == LHU) || (mem_op_i == LW);
    assign is_store  = (mem_op_i == SB) || (mem_op_i == SH) || (mem_op_i == SW);
    assign is_atomic = (mem_op_i == LR_W) || (mem_op_i == SC_W) || (mem_op_i == AMO);
    assign sz_byte   = (mem_op_i == LB) || (mem_op_i == LBU) || (mem_op_i == SB);
    assign sz_half   = (mem_op_i == LH) || (mem_op_i == LHU) || (mem_op_i == SH);

    // read mask stays at lane 0, the aligner picks the lane
    assign rmask = sz_byte ? 4'b0001 :
                   sz_half ? 4'b0011 :
                             4'b1111;
    assign wmask = rmask << addr_i[1:0];

    // store data moved up to the addressed lane
    assign wdata_sh = rs2_i << {addr_i[1:0], 3'b000};

    // four timer registers bypass the cache
    assign timer_hit = (addr_i == `MTIME_LO) || (addr_i == `MTIME_HI) ||
                       (addr_i == `MTIMECMP_LO) || (addr_i == `MTIMECMP_HI);

    assign clint_sel_o   = timer_hit && (is_load || is_store);
    assign clint_we_o    = timer_hit && is_store;
    assign clint_wdata_o = wdata_sh;

    // plain access goes to the cache only off the timer
    assign plain_req = (is_load || is_store) && !timer_hit;

    // cache port, amo traffic is always a full word
    assign mem_req_o   = plain_req || amo_req_i;
    assign mem_we_o    = amo_req_i ? amo_we_i : (plain_req && is_store);
    assign mem_addr_o  = addr_i;
    assign mem_mask_o  = amo_req_i ? 4'b1111 : (is_store ? wmask : rmask);
    assign mem_wdata_o = amo_req_i ? amo_wdata_i : wdata_sh;

    // timer reads complete in the same cycle
    assign rdata_o = timer_hit ? clint_rdata_i : mem_rdata_i;

    // result mux, alu value passes for non-load ops
    always_comb begin
        if (is_atomic) begin
            data_o = amo_result_i;
        end else if (is_load) begin
            data_o = load_data_i;
        end else begin
            data_o = addr_i;
        end
    end

    // hold the pipe until the cache strobes ready or the amo finishes
    assign stall_o = (plain_req && !mem_ready_i) || amo_busy_i;

    // any store breaks the reservation
    assign plain_store_o = is_store;

endmodule

// File: common/lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

    // memory op from the execute stage
    typedef enum logic [`MEMOP_W-1:0] {
        NONE = `MEMOP_NONE,
        LB   = `MEMOP_LB,
        LBU  = `MEMOP_LBU,
        LH   = `MEMOP_LH,
        LHU  = `MEMOP_LHU,
        LW   = `MEMOP_LW,
        SB   = `MEMOP_SB,
        SH   = `MEMOP_SH,
        SW   = `MEMOP_SW,
        LR_W = `MEMOP_LR_W,
        SC_W = `MEMOP_SC_W,
        AMO  = `MEMOP_AMO
    } mem_op_e;

    // read-modify-write function of an amo
    typedef enum logic [`AMOOP_W-1:0] {
        SWAP = `AMOOP_SWAP,
        ADD  = `AMOOP_ADD,
        XOR  = `AMOOP_XOR,
        AND  = `AMOOP_AND,
        OR   = `AMOOP_OR,
        MIN  = `AMOOP_MIN,
        MAX  = `AMOOP_MAX,
        MINU = `AMOOP_MINU,
        MAXU = `AMOOP_MAXU
    } amo_op_e;

    // cache read word, seen as byte lanes or as halfwords
    typedef union packed {
        logic [`XLEN/8-1:0][7:0]   lanes;
        logic [`XLEN/16-1:0][15:0] halves;
    } rd_word_u;

endpackage

// File: common/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// datapath and address width
`define XLEN 32

// op code widths
`define MEMOP_W 4
`define AMOOP_W 4

// machine timer registers, word addressed
`define MTIME_LO    32'h0200_bff8
`define MTIME_HI    32'h0200_bffc
`define MTIMECMP_LO 32'h0200_4000
`define MTIMECMP_HI 32'h0200_4004

// rd value for a failed sc.w
`define SC_FAIL 1

// mem op encodings
`define MEMOP_NONE 4'd0
`define MEMOP_LB   4'd1
`define MEMOP_LBU  4'd2
`define MEMOP_LH   4'd3
`define MEMOP_LHU  4'd4
`define MEMOP_LW   4'd5
`define MEMOP_SB   4'd6
`define MEMOP_SH   4'd7
`define MEMOP_SW   4'd8
`define MEMOP_LR_W 4'd9
`define MEMOP_SC_W 4'd10
`define MEMOP_AMO  4'd11

// amo op encodings, only meaningful with MEMOP_AMO
`define AMOOP_SWAP 4'd0
`define AMOOP_ADD  4'd1
`define AMOOP_XOR  4'd2
`define AMOOP_AND  4'd3
`define AMOOP_OR   4'd4
`define AMOOP_MIN  4'd5
`define AMOOP_MAX  4'd6
`define AMOOP_MINU 4'd7
`define AMOOP_MAXU 4'd8

`endif
